// File: rtl/isp_defines.svh
`ifndef ISP_DEFINES_SVH
`define ISP_DEFINES_SVH

`define PIX_W       8
`define LINE_MAX    1024 // deepest line the buffer holds.
`define COORD_W     12
`define GAIN_W      8
`define GAIN_FRAC   6    // 8'h40 is unity.
`define WB_ADR_W    3
`define WB_DAT_W    8

`define BORDER_RST  8'h01
`define GAIN_UNITY  8'h40

`define ADDR_CTRL   3'd0
`define ADDR_BORDER 3'd1
`define ADDR_GAIN_R 3'd2
`define ADDR_GAIN_G 3'd3
`define ADDR_GAIN_B 3'd4
`define ADDR_FRAMES 3'd5 // read only.

`endif

// File: rtl/isp_video_pkg.sv
package isp_video_pkg;

    // colour at the top-left corner of the mosaic.
    typedef enum logic [1:0] {
        rggb = 2'd0,
        grbg = 2'd1,
        gbrg = 2'd2,
        bggr = 2'd3
    } bayer_phase_e;

    typedef enum logic [1:0] {
        site_r  = 2'd0,
        site_gr = 2'd1, // green on a red row.
        site_gb = 2'd2, // green on a blue row.
        site_b  = 2'd3
    } cfa_site_e;

endpackage

// File: rtl/isp_regs_pkg.sv
`include "isp_defines.svh"

package isp_regs_pkg;

    typedef enum logic [`WB_ADR_W-1:0] {
        reg_ctrl   = `ADDR_CTRL,
        reg_border = `ADDR_BORDER,
        reg_gain_r = `ADDR_GAIN_R,
        reg_gain_g = `ADDR_GAIN_G,
        reg_gain_b = `ADDR_GAIN_B,
        reg_frames = `ADDR_FRAMES
    } reg_addr_e;

    typedef enum logic {
        st_idle = 1'b0,
        st_ack  = 1'b1
    } wb_state_e;

endpackage

// File: rtl/isp_wb_regs.sv
`timescale 1ns/1ps
`include "isp_defines.svh"

module isp_wb_regs
    import isp_regs_pkg::*, isp_video_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`WB_ADR_W-1:0] wb_adr,
    input  logic [`WB_DAT_W-1:0] wb_dat_w,
    output logic [`WB_DAT_W-1:0] wb_dat_r,
    output logic                 wb_ack,
    input  logic                 vsync,
    output bayer_phase_e         phase,
    output logic [`PIX_W-1:0]    border,
    output logic [`GAIN_W-1:0]   gain_r,
    output logic [`GAIN_W-1:0]   gain_g,
    output logic [`GAIN_W-1:0]   gain_b
);
    wb_state_e            state;
    reg_addr_e            addr;
    logic                 req;
    logic                 vsync_d;
    logic [7:0]           frames;
    logic [`WB_DAT_W-1:0] rd_data;

    assign addr   = reg_addr_e'(wb_adr);
    assign req    = wb_cyc && wb_stb && (state == st_idle);
    assign wb_ack = (state == st_ack);

    always_comb begin
        case (addr)
            reg_ctrl:   rd_data = `WB_DAT_W'(phase);
            reg_border: rd_data = border;
            reg_gain_r: rd_data = gain_r;
            reg_gain_g: rd_data = gain_g;
            reg_gain_b: rd_data = gain_b;
            reg_frames: rd_data = frames;
            default:    rd_data = '0; // unmapped.
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state  <= st_idle;
            phase  <= rggb;
            border <= `BORDER_RST;
            gain_r <= `GAIN_UNITY;
            gain_g <= `GAIN_UNITY;
            gain_b <= `GAIN_UNITY;
        end else begin
            state <= req ? st_ack : st_idle; // one-cycle ack.
            if (req && wb_we) begin
                case (addr)
                    reg_ctrl:   phase  <= bayer_phase_e'(wb_dat_w[1:0]);
                    reg_border: border <= wb_dat_w;
                    reg_gain_r: gain_r <= wb_dat_w;
                    reg_gain_g: gain_g <= wb_dat_w;
                    reg_gain_b: gain_b <= wb_dat_w;
                    default:    ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= rd_data;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vsync_d <= 1'b0;
            frames  <= '0;
        end else begin
            vsync_d <= vsync;
            if (vsync && !vsync_d) begin
                frames <= frames + 1'b1; // wraps at 255.
            end
        end
    end

endmodule

// File: rtl/isp_cfa_demosaic.sv
`timescale 1ns/1ps
`include "isp_defines.svh"

module isp_cfa_demosaic
    import isp_video_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              vsync,
    input  logic              hsync,
    input  logic              den,
    input  logic [`PIX_W-1:0] raw,
    input  bayer_phase_e      phase,
    input  logic [`PIX_W-1:0] border,
    output logic              out_vsync,
    output logic              out_hsync,
    output logic              out_den,
    output logic [`PIX_W-1:0] out_r,
    output logic [`PIX_W-1:0] out_g,
    output logic [`PIX_W-1:0] out_b
);
    localparam int LINE_AW = $clog2(`LINE_MAX);

    logic [`COORD_W-1:0] x_cnt;
    logic [`COORD_W-1:0] y_cnt;
    logic                s1_vsync;
    logic                s1_hsync;
    logic                s1_den;
    logic [`COORD_W-1:0] s1_x;
    logic [`COORD_W-1:0] s1_y;
    logic [`PIX_W-1:0]   s1_raw;
    logic [`PIX_W-1:0]   line_buf [`LINE_MAX];
    logic [`PIX_W-1:0]   up_q;
    logic [`PIX_W-1:0]   left_q;
    logic [`PIX_W-1:0]   ul_q;
    logic [1:0]          flip;
    cfa_site_e           site;
    logic [`PIX_W-1:0]   g_cross;
    logic [`PIX_W-1:0]   g_diag;
    logic [`PIX_W-1:0]   next_r;
    logic [`PIX_W-1:0]   next_g;
    logic [`PIX_W-1:0]   next_b;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else begin
            if (!hsync) begin
                x_cnt <= '0;
            end else if (den) begin
                x_cnt <= x_cnt + 1'b1;
            end
            if (!vsync) begin
                y_cnt <= '0;
            end else if (s1_hsync && !hsync) begin
                y_cnt <= y_cnt + 1'b1; // end of line.
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_vsync <= 1'b0;
            s1_hsync <= 1'b0;
            s1_den   <= 1'b0;
            s1_x     <= '0;
            s1_y     <= '0;
        end else begin
            s1_vsync <= vsync;
            s1_hsync <= hsync;
            s1_den   <= den;
            s1_x     <= x_cnt;
            s1_y     <= y_cnt;
        end
    end

    // read the old line before this line overwrites it.
    always_ff @(posedge clk) begin
        s1_raw <= raw;
        up_q   <= line_buf[x_cnt[LINE_AW-1:0]];
        if (s1_den) begin
            line_buf[s1_x[LINE_AW-1:0]] <= s1_raw;
            left_q <= s1_raw;
            ul_q   <= up_q;
        end
    end

    always_comb begin
        case (phase)
            rggb:    flip = 2'b00;
            grbg:    flip = 2'b01;
            gbrg:    flip = 2'b10;
            default: flip = 2'b11;
        endcase
        site = cfa_site_e'({s1_y[0] ^ flip[1], s1_x[0] ^ flip[0]});
    end

    always_comb begin
        g_cross = (up_q >> 1) + (left_q >> 1);
        g_diag  = (s1_raw >> 1) + (ul_q >> 1);
        case (site)
            site_r: begin
                next_r = s1_raw;
                next_g = g_cross;
                next_b = ul_q;
            end
            site_gr: begin
                next_r = left_q;
                next_g = g_diag;
                next_b = up_q;
            end
            site_gb: begin
                next_r = up_q;
                next_g = g_diag;
                next_b = left_q;
            end
            default: begin // blue site.
                next_r = ul_q;
                next_g = g_cross;
                next_b = s1_raw;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_vsync <= 1'b0;
            out_hsync <= 1'b0;
            out_den   <= 1'b0;
            out_r     <= '0;
            out_g     <= '0;
            out_b     <= '0;
        end else begin
            out_vsync <= s1_vsync;
            out_hsync <= s1_hsync;
            out_den   <= s1_den;
            if (!s1_den) begin
                out_r <= '0;
                out_g <= '0;
                out_b <= '0;
            end else if (s1_x == '0 || s1_y == '0) begin
                out_r <= border; // no full neighbourhood.
                out_g <= border;
                out_b <= border;
            end else begin
                out_r <= next_r;
                out_g <= next_g;
                out_b <= next_b;
            end
        end
    end

endmodule

// File: rtl/isp_rgb_gain.sv
`timescale 1ns/1ps
`include "isp_defines.svh"

module isp_rgb_gain (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               in_vsync,
    input  logic               in_hsync,
    input  logic               in_den,
    input  logic [`PIX_W-1:0]  in_r,
    input  logic [`PIX_W-1:0]  in_g,
    input  logic [`PIX_W-1:0]  in_b,
    input  logic [`GAIN_W-1:0] gain_r,
    input  logic [`GAIN_W-1:0] gain_g,
    input  logic [`GAIN_W-1:0] gain_b,
    output logic               out_vsync,
    output logic               out_hsync,
    output logic               out_den,
    output logic [`PIX_W-1:0]  out_r,
    output logic [`PIX_W-1:0]  out_g,
    output logic [`PIX_W-1:0]  out_b
);
    localparam int PROD_W = `PIX_W + `GAIN_W;

    function automatic logic [`PIX_W-1:0] apply_gain(
        input logic [`PIX_W-1:0]  value,
        input logic [`GAIN_W-1:0] gain
    );
        logic [PROD_W-1:0] prod;
        prod = value * gain;
        if (|prod[PROD_W-1:`PIX_W+`GAIN_FRAC]) begin
            return '1; // clip at full scale.
        end
        return prod[`PIX_W+`GAIN_FRAC-1:`GAIN_FRAC];
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_vsync <= 1'b0;
            out_hsync <= 1'b0;
            out_den   <= 1'b0;
            out_r     <= '0;
            out_g     <= '0;
            out_b     <= '0;
        end else begin
            out_vsync <= in_vsync;
            out_hsync <= in_hsync;
            out_den   <= in_den;
            out_r     <= apply_gain(in_r, gain_r);
            out_g     <= apply_gain(in_g, gain_g);
            out_b     <= apply_gain(in_b, gain_b);
        end
    end

endmodule

// File: rtl/isp_top.sv
`timescale 1ns/1ps
`include "isp_defines.svh"

module isp_top
    import isp_video_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 vsync,
    input  logic                 hsync,
    input  logic                 den,
    input  logic [`PIX_W-1:0]    raw,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`WB_ADR_W-1:0] wb_adr,
    input  logic [`WB_DAT_W-1:0] wb_dat_w,
    output logic [`WB_DAT_W-1:0] wb_dat_r,
    output logic                 wb_ack,
    output logic                 out_vsync,
    output logic                 out_hsync,
    output logic                 out_den,
    output logic [`PIX_W-1:0]    out_r,
    output logic [`PIX_W-1:0]    out_g,
    output logic [`PIX_W-1:0]    out_b
);
    bayer_phase_e       phase;
    logic [`PIX_W-1:0]  border;
    logic [`GAIN_W-1:0] gain_r;
    logic [`GAIN_W-1:0] gain_g;
    logic [`GAIN_W-1:0] gain_b;
    logic               dm_vsync;
    logic               dm_hsync;
    logic               dm_den;
    logic [`PIX_W-1:0]  dm_r;
    logic [`PIX_W-1:0]  dm_g;
    logic [`PIX_W-1:0]  dm_b;

    isp_wb_regs regs_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .vsync    (vsync), // counts input frames.
        .phase    (phase),
        .border   (border),
        .gain_r   (gain_r),
        .gain_g   (gain_g),
        .gain_b   (gain_b)
    );

    isp_cfa_demosaic demosaic_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .vsync     (vsync),
        .hsync     (hsync),
        .den       (den),
        .raw       (raw),
        .phase     (phase),
        .border    (border),
        .out_vsync (dm_vsync),
        .out_hsync (dm_hsync),
        .out_den   (dm_den),
        .out_r     (dm_r),
        .out_g     (dm_g),
        .out_b     (dm_b)
    );

    isp_rgb_gain gain_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_vsync  (dm_vsync),
        .in_hsync  (dm_hsync),
        .in_den    (dm_den),
        .in_r      (dm_r),
        .in_g      (dm_g),
        .in_b      (dm_b),
        .gain_r    (gain_r),
        .gain_g    (gain_g),
        .gain_b    (gain_b),
        .out_vsync (out_vsync),
        .out_hsync (out_hsync),
        .out_den   (out_den),
        .out_r     (out_r),
        .out_g     (out_g),
        .out_b     (out_b)
    );

endmodule

// File: tb/tb_isp_top.sv
`timescale 1ns/1ps
`include "isp_defines.svh"

module tb_isp_top
    import isp_regs_pkg::*, isp_video_pkg::*;
();
    localparam int FRAME_W    = 16;
    localparam int FRAME_H    = 8;
    localparam int ACK_WAIT   = 16;
    localparam int DRAIN_WAIT = 32;

    logic                 clk;
    logic                 reset_n;
    logic                 vsync;
    logic                 hsync;
    logic                 den;
    logic [`PIX_W-1:0]    raw;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [`WB_ADR_W-1:0] wb_adr;
    logic [`WB_DAT_W-1:0] wb_dat_w;
    logic [`WB_DAT_W-1:0] wb_dat_r;
    logic                 wb_ack;
    logic                 out_vsync;
    logic                 out_hsync;
    logic                 out_den;
    logic [`PIX_W-1:0]    out_r;
    logic [`PIX_W-1:0]    out_g;
    logic [`PIX_W-1:0]    out_b;

    logic [15:0] lfsr;
    logic [26:0] exp_now; // {vsync, hsync, den, r, g, b}.
    logic [26:0] exp_hist [4];
    logic        mon_en;
    logic        timed_out;
    logic [1:0]  sh_phase;
    logic [7:0]  sh_border;
    logic [7:0]  sh_gain_r;
    logic [7:0]  sh_gain_g;
    logic [7:0]  sh_gain_b;
    logic [7:0]  prev_line [`LINE_MAX];
    logic [7:0]  cur_line [`LINE_MAX];
    int          err_cnt;
    int          video_errs;
    int          sat_cnt;
    int          frames_sent;
    int          tests_run;
    int          tests_bad;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    isp_top dut_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .vsync     (vsync),
        .hsync     (hsync),
        .den       (den),
        .raw       (raw),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .out_vsync (out_vsync),
        .out_hsync (out_hsync),
        .out_den   (out_den),
        .out_r     (out_r),
        .out_g     (out_g),
        .out_b     (out_b)
    );

    // galois form of x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] val;
        logic        bit_out;
        val = '0;
        for (int i = 0; i < n; i++) begin
            bit_out = lfsr[0];
            lfsr = {1'b0, lfsr[15:1]} ^ (bit_out ? 16'hB400 : 16'h0000);
            val = {val[14:0], bit_out};
        end
        return val;
    endfunction

    // 0 red, 1 green on red row, 2 green on blue row, 3 blue.
    function automatic logic [1:0] site_at(input logic [1:0] ph, input int x, input int y);
        logic [7:0] tab;
        int         idx;
        case (ph)
            2'd0:    tab = {2'd3, 2'd2, 2'd1, 2'd0}; // R G / G B.
            2'd1:    tab = {2'd2, 2'd3, 2'd0, 2'd1}; // G R / B G.
            2'd2:    tab = {2'd1, 2'd0, 2'd3, 2'd2}; // G B / R G.
            default: tab = {2'd0, 2'd1, 2'd2, 2'd3}; // B G / G R.
        endcase
        idx = 2 * (y % 2) + (x % 2);
        return tab[idx*2 +: 2];
    endfunction

    function automatic logic [23:0] demosaic_model(input int x, input int y,
            input logic [7:0] cur, input logic [7:0] up,
            input logic [7:0] left, input logic [7:0] ul);
        logic [7:0] g_cross;
        logic [7:0] g_diag;
        if (x == 0 || y == 0) begin
            return {sh_border, sh_border, sh_border};
        end
        g_cross = (up >> 1) + (left >> 1);
        g_diag  = (cur >> 1) + (ul >> 1);
        case (site_at(sh_phase, x, y))
            2'd0:    return {cur, g_cross, ul};
            2'd1:    return {left, g_diag, up};
            2'd2:    return {up, g_diag, left};
            default: return {ul, g_cross, cur};
        endcase
    endfunction

    function automatic logic [7:0] scale_channel(input logic [7:0] v, input logic [7:0] g);
        int prod;
        prod = (int'(v) * int'(g)) >> `GAIN_FRAC;
        if (prod > 255) begin
            return 8'hff;
        end
        return 8'(prod);
    endfunction

    function automatic int clips(input logic [7:0] v, input logic [7:0] g);
        return ((int'(v) * int'(g)) >> `GAIN_FRAC) > 255 ? 1 : 0;
    endfunction

    function automatic logic [7:0] reg_value(input logic [2:0] adr);
        case (adr)
            reg_ctrl:   return {6'b0, sh_phase};
            reg_border: return sh_border;
            reg_gain_r: return sh_gain_r;
            reg_gain_g: return sh_gain_g;
            reg_gain_b: return sh_gain_b;
            reg_frames: return 8'(frames_sent);
            default:    return 8'h00;
        endcase
    endfunction

    // expected output trails the input by three cycles.
    always @(negedge clk) begin
        exp_hist[3] = exp_hist[2];
        exp_hist[2] = exp_hist[1];
        exp_hist[1] = exp_hist[0];
        exp_hist[0] = exp_now;
        if (mon_en) begin
            assert ({out_vsync, out_hsync, out_den, out_r, out_g, out_b} === exp_hist[3])
            else begin
                video_errs++;
                $display("Fail %0t: video out sync %b%b%b rgb %h %h %h, expected %b rgb %h",
                         $time, out_vsync, out_hsync, out_den, out_r, out_g, out_b,
                         exp_hist[3][26:24], exp_hist[3][23:0]);
            end
        end
    end

    task automatic drive_cycle(input logic vs, input logic hs, input logic de,
                               input logic [7:0] pix, input logic [23:0] rgb);
        @(posedge clk);
        vsync <= vs;
        hsync <= hs;
        den   <= de;
        raw   <= pix;
        exp_now = {vs, hs, de, rgb};
    endtask

    task automatic blank_cycles(input int n, input logic vs, input logic hs);
        repeat (n) drive_cycle(vs, hs, 1'b0, 8'h00, 24'h000000);
    endtask

    task automatic wb_cycle(input logic we, input logic [2:0] adr, input logic [7:0] wdat,
                            output logic [7:0] rdat);
        int waited;
        rdat = 8'h00;
        waited = 0;
        if (timed_out) return;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        @(negedge clk);
        while (wb_ack !== 1'b1 && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (wb_ack !== 1'b1) begin
            $display("timeout: no wishbone ack for address %0d", adr);
            timed_out = 1'b1;
        end else begin
            assert (waited == 1) else begin
                err_cnt++;
                $display("Fail %0t: ack after %0d cycles, expected 1", $time, waited);
            end
            rdat = wb_dat_r;
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        assert (wb_ack === 1'b0) else begin
            err_cnt++;
            $display("Fail %0t: ack held for more than one cycle", $time);
        end
    endtask

    task automatic set_reg(input logic [2:0] adr, input logic [7:0] wdat);
        logic [7:0] unused_rd;
        wb_cycle(1'b1, adr, wdat, unused_rd);
        case (adr)
            reg_ctrl:   sh_phase  = wdat[1:0];
            reg_border: sh_border = wdat;
            reg_gain_r: sh_gain_r = wdat;
            reg_gain_g: sh_gain_g = wdat;
            reg_gain_b: sh_gain_b = wdat;
            default:    ;
        endcase
    endtask

    task automatic check_read(input logic [2:0] adr);
        logic [7:0] got;
        wb_cycle(1'b0, adr, 8'h00, got);
        if (!timed_out) begin
            assert (got === reg_value(adr)) else begin
                err_cnt++;
                $display("Fail %0t: register %0d read %h, expected %h",
                         $time, adr, got, reg_value(adr));
            end
        end
    endtask

    task automatic run_frame(input int w, input int h);
        logic [7:0]  pix;
        logic [23:0] rgb;
        int          waited;
        if (timed_out) return;
        blank_cycles(1 + int'(take_bits(3)), 1'b1, 1'b0);
        for (int y = 0; y < h; y++) begin
            blank_cycles(1 + int'(take_bits(2)), 1'b1, 1'b0); // line gap.
            blank_cycles(int'(take_bits(2)), 1'b1, 1'b1);
            for (int x = 0; x < w; x++) begin
                pix = 8'(take_bits(8));
                rgb = demosaic_model(x, y, pix, prev_line[x],
                                     (x > 0) ? cur_line[x-1] : 8'h00,
                                     (x > 0) ? prev_line[x-1] : 8'h00);
                sat_cnt += clips(rgb[23:16], sh_gain_r) + clips(rgb[15:8], sh_gain_g)
                           + clips(rgb[7:0], sh_gain_b);
                rgb = {scale_channel(rgb[23:16], sh_gain_r),
                       scale_channel(rgb[15:8], sh_gain_g),
                       scale_channel(rgb[7:0], sh_gain_b)};
                cur_line[x] = pix;
                drive_cycle(1'b1, 1'b1, 1'b1, pix, rgb);
            end
            blank_cycles(1, 1'b1, 1'b1);
            prev_line = cur_line;
        end
        blank_cycles(2, 1'b1, 1'b0);
        blank_cycles(1, 1'b0, 1'b0);
        frames_sent++;
        waited = 0;
        @(negedge clk);
        while (out_vsync !== 1'b0 && waited < DRAIN_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (out_vsync !== 1'b0) begin
            $display("timeout: out_vsync still high after the end of frame %0d", frames_sent);
            timed_out = 1'b1;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        int errs;
        errs = err_cnt + video_errs - errs_before;
        tests_run++;
        if (errs == 0 && !timed_out) begin
            $display("%-24s ok", name);
        end else begin
            tests_bad++;
            $display("%-24s FAILED, %0d errors", name, errs);
        end
    endtask

    initial begin
        int base;
        reset_n  = 1'b0;
        vsync    = 1'b0;
        hsync    = 1'b0;
        den      = 1'b0;
        raw      = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        lfsr     = 16'd9537;
        exp_now  = '0;
        for (int i = 0; i < 4; i++) exp_hist[i] = '0;
        mon_en     = 1'b0;
        timed_out  = 1'b0;
        sh_phase   = 2'(rggb);
        sh_border  = `BORDER_RST;
        sh_gain_r  = `GAIN_UNITY;
        sh_gain_g  = `GAIN_UNITY;
        sh_gain_b  = `GAIN_UNITY;
        err_cnt    = 0;
        video_errs = 0;
        sat_cnt    = 0;
        frames_sent = 0;
        tests_run  = 0;
        tests_bad  = 0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        mon_en = 1'b1;

        base = err_cnt + video_errs;
        for (int a = 0; a < 5; a++) set_reg(3'(a), 8'(take_bits(8)));
        set_reg(3'd6, 8'(take_bits(8))); // write to an unmapped address.
        for (int a = 0; a < 8; a++) check_read(3'(a));
        end_test("1 register access", base);

        base = err_cnt + video_errs;
        set_reg(reg_ctrl, 8'(rggb));
        set_reg(reg_border, `BORDER_RST);
        set_reg(reg_gain_r, `GAIN_UNITY);
        set_reg(reg_gain_g, `GAIN_UNITY);
        set_reg(reg_gain_b, `GAIN_UNITY);
        run_frame(FRAME_W, FRAME_H);
        end_test("2 demosaic reset values", base);

        base = err_cnt + video_errs;
        for (int p = 0; p < 4; p++) begin
            set_reg(reg_ctrl, {6'(take_bits(6)), 2'(p)});
            set_reg(reg_border, 8'(take_bits(8)));
            run_frame(FRAME_W, FRAME_H);
        end
        end_test("3 bayer phases", base);

        base = err_cnt + video_errs;
        sat_cnt = 0;
        set_reg(reg_gain_r, 8'(take_bits(8)));
        set_reg(reg_gain_g, 8'(take_bits(8)));
        set_reg(reg_gain_b, 8'(take_bits(8)));
        run_frame(FRAME_W, FRAME_H);
        set_reg(reg_gain_r, 8'h80 | 8'(take_bits(7))); // at least 2x.
        set_reg(reg_gain_g, 8'h80 | 8'(take_bits(7)));
        set_reg(reg_gain_b, 8'h80 | 8'(take_bits(7)));
        run_frame(FRAME_W, FRAME_H);
        assert (sat_cnt > 0 || timed_out) else begin
            err_cnt++;
            $display("no output pixel reached saturation during the gain frames");
        end
        end_test("4 gain and saturation", base);

        base = err_cnt + video_errs;
        set_reg(reg_gain_r, `GAIN_UNITY);
        set_reg(reg_gain_g, `GAIN_UNITY);
        set_reg(reg_gain_b, `GAIN_UNITY);
        for (int f = 0; f < 3; f++) run_frame(FRAME_W - 4 * f, 4);
        check_read(reg_frames);
        end_test("5 sync and frame count", base);

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_bad, err_cnt + video_errs);
        if (timed_out || tests_bad != 0) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+rtl
rtl/isp_video_pkg.sv
rtl/isp_regs_pkg.sv
rtl/isp_wb_regs.sv
rtl/isp_cfa_demosaic.sv
rtl/isp_rgb_gain.sv
rtl/isp_top.sv
tb/tb_isp_top.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, then scan the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -j 0 --top-module tb_isp_top -Mdir obj_dir -f files.f \
    && ./obj_dir/Vtb_isp_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "verilator build or simulation run did not complete"; exit 1; }
cat sim.log
! grep -q "test failed" sim.log && grep -q "test passed" sim.log
